// File: flist.f
+incdir+verif
src/pmp_pkg.sv
src/pmp_matcher.sv
src/pmp_csr_file.sv
src/pmp_checker.sv
src/pmp_top.sv
verif/pmp_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module pmp_tb -f flist.f -o pmp_tb_sim
	./obj_dir/pmp_tb_sim | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/pmp_model.svh
// PMP reference model for the testbench
// shadow CSR state with lock and WR legalization, plus access decision
logic [7:0]  m_cfg  [pmp_entries];         // l 7, rsvd 6:5, a 4:3, x 2, w 1, r 0
logic [31:0] m_addr [pmp_entries];

function automatic void clear_shadow();
  for (int i = 0; i < pmp_entries; i++) begin
    m_cfg[i]  = '0;
    m_addr[i] = '0;
  end
endfunction

function automatic logic addr_locked(input int i);
  if (m_cfg[i][7]) return 1'b1;            // own lock
  if (i < pmp_entries - 1) begin
    if (m_cfg[i+1][7] && m_cfg[i+1][4:3] == 2'b01) return 1'b1; // locked tor above
  end
  return 1'b0;
endfunction

function automatic void write_shadow(input logic [11:0] ca, input logic [31:0] wd);
  logic [7:0] nb;
  for (int w = 0; w < pmp_cfg_words; w++) begin
    if (ca == csr_pmpcfg0 + 12'(w)) begin
      for (int b = 0; b < 4; b++) begin
        nb      = wd[8*b +: 8];
        nb[6:5] = 2'b00;                   // reserved reads zero
        if (!nb[0]) nb[1] = 1'b0;          // no write permission without read
        if (!m_cfg[4*w+b][7]) m_cfg[4*w+b] = nb;
      end
    end
  end
  for (int i = 0; i < pmp_entries; i++) begin
    if (ca == csr_pmpaddr0 + 12'(i) && !addr_locked(i)) m_addr[i] = wd;
  end
endfunction

function automatic logic [31:0] read_shadow(input logic [11:0] ca);
  logic [31:0] r;
  r = '0;                                  // unimplemented numbers
  for (int w = 0; w < pmp_cfg_words; w++) begin
    if (ca == csr_pmpcfg0 + 12'(w)) begin
      for (int b = 0; b < 4; b++) r[8*b +: 8] = m_cfg[4*w+b];
    end
  end
  for (int i = 0; i < pmp_entries; i++) begin
    if (ca == csr_pmpaddr0 + 12'(i)) r = m_addr[i];
  end
  return r;
endfunction

function automatic logic entry_matches(input int i, input logic [31:0] a);
  logic [31:0] pa;
  logic [31:0] lo;
  int          k;
  pa = m_addr[i];
  lo = '0;                                 // entry 0 tor floor
  if (i > 0) lo = m_addr[i-1];
  k = 0;
  while (k < 32 && pa[k]) k++;             // trailing ones
  case (m_cfg[i][4:3])
    2'b01:   return (lo < pa) && (a >= lo) && (a < pa);
    2'b10:   return a == pa;
    2'b11:   return (k < 32) && ((a >> (k + 1)) == (pa >> (k + 1)));
    default: return 1'b0;
  endcase
endfunction

function automatic pmp_resp_t expected_resp(input pmp_req_t rq);
  pmp_resp_t r;
  logic      perm;
  r       = '0;
  r.fault = (rq.priv != priv_m);           // miss: only machine mode passes
  for (int i = 0; i < pmp_entries; i++) begin
    if (!r.hit && entry_matches(i, rq.addr)) begin
      r.hit   = 1'b1;
      r.entry = pmp_idx_w'(i);
      case (rq.acc)
        acc_read:  perm = m_cfg[i][0];
        acc_write: perm = m_cfg[i][1];
        default:   perm = m_cfg[i][2];
      endcase
      r.fault = !(perm || (rq.priv == priv_m && !m_cfg[i][7]));
    end
  end
  return r;
endfunction

// File: verif/pmp_tb.sv
// PMP checker testbench
// random CSR writes and access requests checked against a reference model
module pmp_tb;

  import pmp_pkg::*;

  localparam int clk_period   = 4;
  localparam int reset_cycles = 5;
  localparam int p2_writes    = 200;
  localparam int p3_rounds    = 4;            // 18 cycles each after reset
  localparam int p4_rounds    = 20;           // 34 cycles each
  localparam int p5_cycles    = 300;
  localparam int total_cycles = (reset_cycles + 1) * (p3_rounds + 3) + 52 + 2 * p2_writes +
                                p3_rounds * 18 + p4_rounds * 34 + p5_cycles;

  logic        clk = 1'b0;
  logic        reset;
  logic        csr_we;
  logic [11:0] csr_addr;
  logic [31:0] csr_wdata;
  logic [31:0] csr_rdata;
  logic        req_valid;
  pmp_req_t    req;
  logic        resp_valid;
  pmp_resp_t   resp;

  pmp_resp_t   exp_q [$];                     // responses in flight
  int          mismatches   = 0;
  int          other_errors = 0;

  `include "pmp_model.svh"

  pmp_top i_pmp_top (.*);

  initial begin
    forever #(clk_period / 2) clk = ~clk;
  end

  // runs at the falling edge, outputs settled
  task automatic check_outputs();
    pmp_resp_t exp;
    if (csr_rdata !== read_shadow(csr_addr)) begin
      mismatches++;
      $display("MISMATCH at %0t: csr %h read %h, expected %h", $time, csr_addr, csr_rdata,
               read_shadow(csr_addr));
    end
    if (resp_valid && exp_q.size() == 0) begin
      other_errors++;
      $display("ERROR at %0t: resp_valid high with no request outstanding", $time);
    end else if (!resp_valid && exp_q.size() != 0) begin
      other_errors++;
      $display("ERROR at %0t: no response one cycle after a request", $time);
      exp_q.delete();
    end else if (resp_valid) begin
      exp = exp_q.pop_front();
      if (resp !== exp) begin
        mismatches++;
        $display("MISMATCH at %0t: fault %b hit %b entry %0d, expected %b %b %0d", $time,
                 resp.fault, resp.hit, resp.entry, exp.fault, exp.hit, exp.entry);
      end
    end
  endtask

  // one cycle of stimulus, then check at the next falling edge
  task automatic step(input logic we, input logic [11:0] ca, input logic [31:0] wd,
                      input logic rv, input pmp_req_t rq);
    csr_we    = we;
    csr_addr  = ca;
    csr_wdata = wd;
    req_valid = rv;
    req       = rq;
    if (rv) exp_q.push_back(expected_resp(rq));  // config before this cycle's write
    if (we) write_shadow(ca, wd);
    @(negedge clk);
    check_outputs();
  endtask

  task automatic apply_reset();
    reset     = 1'b1;
    csr_we    = 1'b0;
    csr_addr  = '0;
    csr_wdata = '0;
    req_valid = 1'b0;
    req       = '0;
    clear_shadow();
    exp_q.delete();
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_outputs();
  endtask

  // biased toward stored bounds, edges and napot limits
  function automatic logic [31:0] pick_addr();
    int          j;
    logic [31:0] a;
    logic [31:0] lo;
    j  = $urandom_range(0, pmp_entries - 1);
    a  = m_addr[j];
    lo = '0;
    if (j > 0) lo = m_addr[j-1];
    case ($urandom_range(0, 8))
      0:       return a;
      1:       return a - 1;
      2:       return a + 1;
      3:       return lo;
      4:       return lo - 1;
      5:       return a & (a + 1);            // napot region base
      6:       return (a | (a + 1)) + 1;      // just past napot region
      7:       return $urandom & 32'hFFF;
      default: return $urandom;
    endcase
  endfunction

  function automatic pmp_req_t make_req();
    pmp_req_t rq;
    rq.addr = pick_addr();
    rq.acc  = access_t'(2'($urandom_range(0, 2)));
    case ($urandom_range(0, 2))
      0:       rq.priv = priv_u;
      1:       rq.priv = priv_s;
      default: rq.priv = priv_m;
    endcase
    return rq;
  endfunction

  // small values often, so regions overlap
  function automatic logic [31:0] rand_addr_val();
    return $urandom_range(0, 1) ? ($urandom & 32'hFFF) : $urandom;
  endfunction

  initial begin
    int          e;
    logic [31:0] w;
    logic [11:0] ca;
    logic [1:0]  md;
    pmp_req_t    rq;
    void'($urandom(43187));
    apply_reset();
    // reset state, all entries off
    for (int i = 0; i < 10; i++) step(1'b0, csr_pmpcfg0 + 12'(i < 2 ? i : i + 14), '0, 1'b0, '0);
    step(1'b0, 12'h3A2, '0, 1'b0, '0);
    step(1'b0, 12'h300, '0, 1'b0, '0);
    repeat (40) step(1'b0, 12'h000, '0, 1'b1, make_req());
    // random CSR writes, lock bits kept clear
    repeat (p2_writes) begin
      case ($urandom_range(0, 9))
        0, 1:    ca = csr_pmpcfg0 + 12'($urandom_range(0, 1));
        9:       ca = 12'($urandom);          // mostly unimplemented numbers
        default: ca = csr_pmpaddr0 + 12'($urandom_range(0, 7));
      endcase
      step(1'b1, ca, $urandom & 32'h7F7F_7F7F, 1'b0, '0);
      e = $urandom_range(0, 9);               // any implemented CSR, unwritten ones too
      step(1'b0, csr_pmpcfg0 + 12'(e < 2 ? e : e + 14), '0, 1'b0, '0);
    end
    // lock one entry, then try to overwrite it
    for (int round = 0; round < p3_rounds; round++) begin
      apply_reset();
      e = $urandom_range(1, pmp_entries - 1);
      step(1'b1, csr_pmpaddr0 + 12'(e - 1), $urandom & 32'hFF, 1'b0, '0);
      step(1'b1, csr_pmpaddr0 + 12'(e), m_addr[e-1] + 1 + ($urandom & 32'hFF), 1'b0, '0);
      ca = csr_pmpcfg0 + 12'(e / 4);
      w  = read_shadow(ca);
      md = (round == 0) ? 2'b01 : 2'($urandom_range(1, 3));  // first round always tor
      w[8*(e%4) +: 8] = {1'b1, 2'b00, md, 3'($urandom)};
      step(1'b1, ca, w, 1'b0, '0);
      step(1'b1, ca, $urandom, 1'b0, '0);
      step(1'b1, csr_pmpaddr0 + 12'(e), $urandom, 1'b0, '0);
      step(1'b1, csr_pmpaddr0 + 12'(e - 1), $urandom, 1'b0, '0);  // held under locked tor
      for (int i = 0; i < 12; i++) begin
        rq = make_req();
        if (i < 8) rq.priv = priv_m;
        if (i % 2 == 0) rq.addr = m_addr[e] - 32'(i % 4 / 2);
        step(1'b0, 12'h000, '0, 1'b1, rq);
      end
    end
    // mixed region configurations
    apply_reset();
    repeat (p4_rounds) begin
      for (int i = 0; i < pmp_entries; i++) begin
        step(1'b1, csr_pmpaddr0 + 12'(i), rand_addr_val(), 1'b0, '0);
      end
      for (int i = 0; i < pmp_cfg_words; i++) begin
        step(1'b1, csr_pmpcfg0 + 12'(i), $urandom & 32'h7F7F_7F7F, 1'b0, '0);
      end
      repeat (24) step(1'b0, 12'h000, '0, 1'b1, make_req());
    end
    // back to back requests with writes in the same cycles
    apply_reset();
    repeat (p5_cycles) begin
      ca = $urandom_range(0, 1) ? csr_pmpcfg0 + 12'($urandom_range(0, 1))
                                : csr_pmpaddr0 + 12'($urandom_range(0, 7));
      w  = $urandom_range(0, 1) ? ($urandom & 32'h7F7F_7F7F) : rand_addr_val();
      step($urandom_range(0, 2) == 0, ca, w, 1'b1, make_req());
    end
    $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #((total_cycles + 100) * clk_period);
    $display("ERROR: watchdog expired after %0d cycles, run did not finish", total_cycles + 100);
    $display("errors: %0d mismatches, %0d other", mismatches, other_errors + 1);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: src/pmp_top.sv
// PMP top level
// CSR file feeding the access checker
module pmp_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               csr_we,
  input  logic [11:0]        csr_addr,
  input  logic [31:0]        csr_wdata,
  output logic [31:0]        csr_rdata,
  input  logic               req_valid,
  input  pmp_pkg::pmp_req_t  req,
  output logic               resp_valid,
  output pmp_pkg::pmp_resp_t resp
);

  import pmp_pkg::*;

  pmpcfg_base_t cfg  [pmp_entries];   // stored entry configs
  pmpaddr_t     addr [pmp_entries];   // stored entry addresses

  pmp_csr_file i_pmp_csr_file (
    .clk       (clk),
    .reset     (reset),
    .csr_we    (csr_we),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .csr_rdata (csr_rdata),
    .cfg       (cfg),
    .addr      (addr)
  );

  pmp_checker i_pmp_checker (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .cfg        (cfg),
    .addr       (addr),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

endmodule

// File: src/pmp_checker.sv
// PMP access checker
// per entry matchers, lowest index priority, privilege rules,
// one cycle registered allow or fault response
module pmp_checker (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_valid,                      // one request per cycle
  input  pmp_pkg::pmp_req_t     req,
  input  pmp_pkg::pmpcfg_base_t cfg  [pmp_pkg::pmp_entries],
  input  pmp_pkg::pmpaddr_t     addr [pmp_pkg::pmp_entries],
  output logic                  resp_valid,                     // req_valid delayed a cycle
  output pmp_pkg::pmp_resp_t    resp                            // holds while not valid
);

  import pmp_pkg::*;

  logic [pmp_entries-1:0] match;            // per entry match
  pmpaddr_t               prev_addr [pmp_entries]; // tor lower bound per entry
  logic                   hit;
  logic [pmp_idx_w-1:0]   hit_idx;          // lowest matching entry
  pmpcfg_base_t           hit_cfg;
  logic                   perm;             // rwx bit for this access type
  logic                   allow;

  for (genvar i = 0; i < pmp_entries; i++) begin : g_match
    if (i == 0) begin : g_first
      assign prev_addr[i] = '0;             // entry 0 tor starts at zero
    end else begin : g_next
      assign prev_addr[i] = addr[i-1];
    end

    pmp_matcher i_pmp_matcher (
      .phys_addr       (req.addr),
      .check_cfg       (cfg[i]),
      .cfg_addr        (addr[i]),
      .cfg_addr_before (prev_addr[i]),
      .match           (match[i])
    );
  end

  // scan downward so the lowest index wins
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = pmp_entries - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit     = 1'b1;
        hit_idx = pmp_idx_w'(i);
      end
    end
  end

  assign hit_cfg = cfg[hit_idx];

  always_comb begin
    case (req.acc)
      acc_read:  perm = hit_cfg.r;
      acc_write: perm = hit_cfg.w;
      acc_exec:  perm = hit_cfg.x;
      default:   perm = 1'b0;               // unused encoding
    endcase
  end

  always_comb begin
    if (hit) begin
      // unlocked entries do not restrict machine mode
      allow = ((req.priv == priv_m) && !hit_cfg.l) || perm;
    end else begin
      allow = (req.priv == priv_m);         // no match, only m passes
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_valid <= 1'b0;
      resp       <= '0;
    end else begin
      resp_valid <= req_valid;
      if (req_valid) begin
        resp.fault <= !allow;
        resp.hit   <= hit;
        resp.entry <= hit_idx;             // zero on miss
      end
    end
  end

endmodule

// File: src/pmp_csr_file.sv
// PMP CSR file
// pmpcfg and pmpaddr storage with lock and WR legalization, CSR read mux
module pmp_csr_file (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  csr_we,                          // one cycle write strobe
  input  logic [11:0]           csr_addr,
  input  logic [31:0]           csr_wdata,
  output logic [31:0]           csr_rdata,                       // combinational read
  output pmp_pkg::pmpcfg_base_t cfg  [pmp_pkg::pmp_entries],
  output pmp_pkg::pmpaddr_t     addr [pmp_pkg::pmp_entries]
);

  import pmp_pkg::*;

  pmpcfg_word_u cfg_q     [pmp_cfg_words];   // stored pmpcfg words
  pmpcfg_word_u cfg_legal [pmp_cfg_words];   // legalized value if written now
  pmpcfg_word_u cfg_wr;                      // write data seen as entry bytes
  pmpaddr_t     addr_q    [pmp_entries];
  logic [pmp_entries-1:0] addr_lock;         // pmpaddr write blocked

  // locked byte keeps old value, else clear rsvd and drop w without r
  function automatic pmpcfg_base_t legalize_byte(input pmpcfg_base_t old_b,
                                                 input pmpcfg_base_t new_b);
    pmpcfg_base_t res;
    res      = new_b;
    res.rsvd = 2'b00;
    if (!new_b.r) res.w = 1'b0;              // w=1 r=0 reserved
    if (old_b.l) res = old_b;
    return res;
  endfunction

  always_comb begin
    cfg_wr.raw = csr_wdata;
    for (int w = 0; w < pmp_cfg_words; w++) begin
      for (int b = 0; b < pmp_cfg_per_word; b++) begin
        cfg_legal[w].cfg[b] = legalize_byte(cfg_q[w].cfg[b], cfg_wr.cfg[b]);
      end
    end
  end

  for (genvar i = 0; i < pmp_entries; i++) begin : g_entry
    assign cfg[i]  = cfg_q[i / pmp_cfg_per_word].cfg[i % pmp_cfg_per_word];
    assign addr[i] = addr_q[i];
    if (i == pmp_entries - 1) begin : g_last
      assign addr_lock[i] = cfg[i].l;        // no entry above
    end else begin : g_mid
      // own lock, or locked tor entry above uses this as lower bound
      assign addr_lock[i] = cfg[i].l | (cfg[i+1].l & (cfg[i+1].a == tor));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < pmp_cfg_words; w++) cfg_q[w].raw <= '0;
      for (int i = 0; i < pmp_entries; i++) addr_q[i] <= '0;
    end else if (csr_we) begin
      for (int w = 0; w < pmp_cfg_words; w++) begin
        if (csr_addr == csr_pmpcfg0 + 12'(w)) cfg_q[w].raw <= cfg_legal[w].raw;
      end
      for (int i = 0; i < pmp_entries; i++) begin
        if (csr_addr == csr_pmpaddr0 + 12'(i) && !addr_lock[i]) addr_q[i] <= csr_wdata;
      end
    end
  end

  // unknown CSR numbers read zero
  always_comb begin
    csr_rdata = '0;
    for (int w = 0; w < pmp_cfg_words; w++) begin
      if (csr_addr == csr_pmpcfg0 + 12'(w)) csr_rdata = cfg_q[w].raw;
    end
    for (int i = 0; i < pmp_entries; i++) begin
      if (csr_addr == csr_pmpaddr0 + 12'(i)) csr_rdata = addr_q[i];
    end
  end

endmodule

// File: src/pmp_matcher.sv
// PMP entry matcher
// combinational address match of one entry for OFF, TOR, NA4 and NAPOT
module pmp_matcher (
  input  pmp_pkg::pmpaddr_t     phys_addr,         // word address under test
  input  pmp_pkg::pmpcfg_base_t check_cfg,         // this entry's config byte
  input  pmp_pkg::pmpaddr_t     cfg_addr,          // this entry's pmpaddr
  input  pmp_pkg::pmpaddr_t     cfg_addr_before,   // previous pmpaddr, tor lower bound
  output logic                  match
);

  import pmp_pkg::*;

  logic [5:0]  ones_cnt;                           // trailing ones of cfg_addr, 32 if all ones
  logic [5:0]  shift_amt;                          // region size bits, k + 1
  logic [31:0] napot_mask;                         // ones where bits are compared
  logic        napot_hit;
  logic        tor_hit;

  // lowest zero bit position gives the trailing ones count
  always_comb begin
    ones_cnt = 6'd32;
    for (int i = 31; i >= 0; i--) begin
      if (!cfg_addr[i]) ones_cnt = 6'(i);
    end
  end

  assign shift_amt  = ones_cnt + 6'd1;             // k=31 gives 32, mask all clear
  assign napot_mask = 32'hFFFF_FFFF << shift_amt;  // bits above position k

  // all ones encoding has no meaningful size, never matches
  assign napot_hit = (cfg_addr != 32'hFFFF_FFFF) &&
                     ((phys_addr & napot_mask) == (cfg_addr & napot_mask));

  // empty or inverted range never matches
  assign tor_hit = (cfg_addr_before < cfg_addr) &&
                   (phys_addr >= cfg_addr_before) && (phys_addr < cfg_addr);

  always_comb begin
    match = 1'b0;
    case (check_cfg.a)
      na4: begin
        match = (phys_addr == cfg_addr);           // single word
      end
      tor: begin
        match = tor_hit;
      end
      napot: begin
        match = napot_hit;
      end
      off: begin
        match = 1'b0;
      end
      default: begin
        match = 1'b0;
      end
    endcase
  end

endmodule

// File: src/pmp_pkg.sv
// PMP shared definitions
// entry config and address types, CSR numbers, access request and response
package pmp_pkg;

  localparam int pmp_entries      = 8;                    // number of PMP entries
  localparam int pmp_cfg_per_word = 4;                    // entry bytes per pmpcfg CSR
  localparam int pmp_cfg_words    = pmp_entries / pmp_cfg_per_word; // pmpcfg0, pmpcfg1
  localparam int pmp_idx_w        = $clog2(pmp_entries);  // entry index width

  localparam logic [11:0] csr_pmpcfg0  = 12'h3A0;         // pmpcfg1 at next number
  localparam logic [11:0] csr_pmpaddr0 = 12'h3B0;         // pmpaddr0..7 consecutive

  typedef enum logic [1:0] {
    off   = 2'b00,                                        // entry disabled
    tor   = 2'b01,                                        // top of range
    na4   = 2'b10,                                        // naturally aligned word
    napot = 2'b11                                         // naturally aligned power of two
  } pmp_mode_t;

  typedef struct packed {
    logic      l;                                         // lock
    logic [1:0] rsvd;                                     // reads back zero
    pmp_mode_t a;                                         // address match mode
    logic      x;
    logic      w;
    logic      r;
  } pmpcfg_base_t;

  typedef logic [31:0] pmpaddr_t;                         // word granule, pa[33:2]

  // one pmpcfg CSR word, seen whole or as its four entry bytes
  typedef union packed {
    logic [31:0]                             raw;
    pmpcfg_base_t [pmp_cfg_per_word-1:0]     cfg;         // cfg[0] in bits 7:0
  } pmpcfg_word_u;

  typedef enum logic [1:0] {
    acc_read  = 2'b00,
    acc_write = 2'b01,
    acc_exec  = 2'b10
  } access_t;

  typedef enum logic [1:0] {
    priv_u = 2'b00,
    priv_s = 2'b01,
    priv_m = 2'b11                                        // isa encoding of machine mode
  } priv_t;

  typedef struct packed {
    pmpaddr_t addr;                                       // word address, pa[33:2]
    access_t  acc;
    priv_t    priv;
  } pmp_req_t;

  typedef struct packed {
    logic                 fault;
    logic                 hit;
    logic [pmp_idx_w-1:0] entry;                          // deciding entry, zero on miss
  } pmp_resp_t;

endpackage
